//--- hdl/ooo_macros.svh
`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

// Data and instruction word width
`define OOO_XLEN       32
// PC and Wishbone byte address
`define OOO_PC_W       12

// Architectural register index
`define OOO_AREG_W     5
// Physical register file size and index
`define OOO_NUM_PREGS  40
`define OOO_PREG_W     6
// Registers beyond the 32 architectural ones
`define OOO_FREE_DEPTH 8

// Reorder buffer size and tag
`define OOO_ROB_DEPTH  16
`define OOO_ROB_TAG_W  4

`endif

//--- hdl/ooo_pkg.sv
`include "ooo_macros.svh"

package ooo_pkg;

  // Functional unit class, branch kept at 2'b01
  typedef enum logic [1:0] {
    FU_ALU    = 2'b00,
    FU_BRANCH = 2'b01,
    FU_LSU    = 2'b10
  } futype_e;

  // ALU operation class
  // ADD for address calc, CMP for branch, FUNCT from funct3/funct7
  typedef enum logic [1:0] {
    ALU_ADD   = 2'b00,
    ALU_CMP   = 2'b01,
    ALU_FUNCT = 2'b10
  } alu_op_e;

  // ------------------------------
  // Stage payloads
  // ------------------------------

  // Fetch to decode
  typedef struct packed {
    logic [`OOO_XLEN-1:0] instr;
    logic [`OOO_PC_W-1:0] pc;
  } fetch_pkt_t;

  // Decode to rename, architectural register names
  typedef struct packed {
    logic [`OOO_PC_W-1:0]   pc;
    logic [`OOO_AREG_W-1:0] rs1;
    logic [`OOO_AREG_W-1:0] rs2;
    logic [`OOO_AREG_W-1:0] rd;
    logic                   has_dest;
    futype_e                futype;
    alu_op_e                alu_op;
    logic [`OOO_XLEN-1:0]   imm;
  } dec_uop_t;

  // Rename to dispatch, physical register names
  typedef struct packed {
    logic [`OOO_PC_W-1:0]   pc;
    logic [`OOO_PREG_W-1:0] prs1;
    logic [`OOO_PREG_W-1:0] prs2;
    logic [`OOO_PREG_W-1:0] prd;
    logic [`OOO_PREG_W-1:0] old_prd;
    logic                   has_dest;
    futype_e                futype;
    alu_op_e                alu_op;
    logic [`OOO_XLEN-1:0]   imm;
  } ren_uop_t;

  // Issue port payload
  typedef struct packed {
    ren_uop_t                  ren;
    logic [`OOO_ROB_TAG_W-1:0] rob_tag;
  } uop_t;

  // Retirement record, old_prd goes back to the free list
  typedef struct packed {
    logic [`OOO_ROB_TAG_W-1:0] rob_tag;
    logic [`OOO_PREG_W-1:0]    old_prd;
    logic                      has_dest;
  } commit_t;

endpackage

//--- hdl/ooo_fetch.sv
`timescale 1ns/1ps
`include "ooo_macros.svh"

module ooo_fetch (
  input  logic                 clk,
  input  logic                 i_arst_n,
  // Wishbone classic read master
  output logic                 o_wb_cyc,
  output logic                 o_wb_stb,
  output logic [`OOO_PC_W-1:0] o_wb_adr,
  input  logic [`OOO_XLEN-1:0] i_wb_dat,
  input  logic                 i_wb_ack,
  // Fetch packet stream
  output ooo_pkg::fetch_pkt_t  o_pkt,
  output logic                 o_valid,
  input  logic                 i_ready
);

  localparam int PC_W = `OOO_PC_W;

  // Idle only right after reset
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_HOLD
  } state_e;

  state_e          state_q;
  state_e          state_d;
  logic [PC_W-1:0] pc_q;
  logic            ack_take;

  // Bus cycle ends on ack while requesting
  assign ack_take = (state_q == ST_REQ) && i_wb_ack;

  // Cyc and stb share the request state
  assign o_wb_cyc = (state_q == ST_REQ);
  assign o_wb_stb = (state_q == ST_REQ);
  // Address is the PC, held until ack
  assign o_wb_adr = pc_q;

  // Packet register is full only in hold
  assign o_valid  = (state_q == ST_HOLD);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: state_d = ST_REQ;
      // Wait out the slave's wait states
      ST_REQ:  if (i_wb_ack) state_d = ST_HOLD;
      // Next read once the packet drains
      ST_HOLD: if (i_ready) state_d = ST_REQ;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= ST_IDLE;
      pc_q    <= '0;
    end else begin
      state_q <= state_d;
      // Sequential fetch, no redirect
      if (ack_take) pc_q <= pc_q + PC_W'(4);
    end
  end

  // Data captured in the ack cycle
  always_ff @(posedge clk) begin
    if (ack_take) begin
      o_pkt.instr <= i_wb_dat;
      o_pkt.pc    <= pc_q;
    end
  end

endmodule

//--- hdl/ooo_skid_buffer.sv
`timescale 1ns/1ps

module ooo_skid_buffer #(
  parameter type T = logic [31:0]
) (
  input  logic clk,
  input  logic i_arst_n,
  // Upstream side
  input  T     i_data,
  input  logic i_valid,
  output logic o_ready,
  // Downstream side
  output T     o_data,
  output logic o_valid,
  input  logic i_ready
);

  T     main_q;
  T     skid_q;
  logic main_valid_q;
  logic skid_valid_q;
  logic main_load;
  logic skid_load;

  // Main register free or draining this cycle
  assign main_load = i_ready || !main_valid_q;
  // Downstream stalled, park the incoming beat
  assign skid_load = !main_load && i_valid && !skid_valid_q;

  // Ready straight from a flop
  assign o_ready = !skid_valid_q;
  assign o_valid = main_valid_q;
  assign o_data  = main_q;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (main_load) begin
      // Skid entry is older, it goes first
      main_valid_q <= skid_valid_q || i_valid;
      skid_valid_q <= 1'b0;
    end else if (skid_load) begin
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (main_load) main_q <= skid_valid_q ? skid_q : i_data;
    if (skid_load) skid_q <= i_data;
  end

endmodule

//--- hdl/ooo_decode.sv
`timescale 1ns/1ps
`include "ooo_macros.svh"

module ooo_decode (
  input  ooo_pkg::fetch_pkt_t i_pkt,
  input  logic                i_valid,
  output logic                o_ready,
  output ooo_pkg::dec_uop_t   o_uop,
  output logic                o_valid,
  input  logic                i_ready
);
  import ooo_pkg::*;

  // RV32I major opcodes handled here
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  logic [`OOO_XLEN-1:0] ins;
  logic [6:0]           opcode;
  logic [`OOO_XLEN-1:0] imm_i;
  logic [`OOO_XLEN-1:0] imm_s;
  logic [`OOO_XLEN-1:0] imm_b;
  logic                 writes_rd;

  assign ins    = i_pkt.instr;
  assign opcode = ins[6:0];

  // Sign-extended immediates, B-type has implicit bit 0
  assign imm_i = {{20{ins[31]}}, ins[31:20]};
  assign imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
  assign imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};

  // Pure combinational stage
  assign o_valid = i_valid;
  assign o_ready = i_ready;

  always_comb begin
    // Default is OP-IMM, also the fallback for unknown opcodes
    o_uop.pc     = i_pkt.pc;
    o_uop.rs1    = ins[19:15];
    o_uop.rs2    = '0;
    o_uop.futype = FU_ALU;
    o_uop.alu_op = ALU_FUNCT;
    o_uop.imm    = imm_i;
    writes_rd    = 1'b0;
    case (opcode)
      OPC_OP: begin
        o_uop.rs2 = ins[24:20];
        o_uop.imm = '0;
        writes_rd = 1'b1;
      end
      OPC_OPIMM: writes_rd = 1'b1;
      OPC_LOAD: begin
        o_uop.futype = FU_LSU;
        o_uop.alu_op = ALU_ADD;
        writes_rd    = 1'b1;
      end
      // Store and branch reuse the rd field as immediate bits
      OPC_STORE: begin
        o_uop.rs2    = ins[24:20];
        o_uop.futype = FU_LSU;
        o_uop.alu_op = ALU_ADD;
        o_uop.imm    = imm_s;
      end
      OPC_BRANCH: begin
        o_uop.rs2    = ins[24:20];
        o_uop.futype = FU_BRANCH;
        o_uop.alu_op = ALU_CMP;
        o_uop.imm    = imm_b;
      end
      default: writes_rd = 1'b0;
    endcase
    // x0 never gets a physical register
    o_uop.has_dest = writes_rd && (ins[11:7] != '0);
    o_uop.rd       = o_uop.has_dest ? ins[11:7] : '0;
  end

endmodule

//--- hdl/ooo_rename.sv
`timescale 1ns/1ps
`include "ooo_macros.svh"

module ooo_rename (
  input  logic              clk,
  input  logic              i_arst_n,
  // From skid 2
  input  ooo_pkg::dec_uop_t i_uop,
  input  logic              i_valid,
  output logic              o_ready,
  // To skid 3
  output ooo_pkg::ren_uop_t o_uop,
  output logic              o_valid,
  input  logic              i_ready,
  // Retired registers from the ROB
  input  ooo_pkg::commit_t  i_commit,
  input  logic              i_commit_valid
);

  localparam int PREG_W    = `OOO_PREG_W;
  localparam int NUM_AREGS = 2 ** `OOO_AREG_W;
  localparam int FL_DEPTH  = `OOO_FREE_DEPTH;
  localparam int FL_PTR_W  = $clog2(FL_DEPTH);
  localparam int FL_CNT_W  = $clog2(FL_DEPTH + 1);

  // Register alias table
  logic [PREG_W-1:0]   rat_q [NUM_AREGS];

  // Free list FIFO
  logic [PREG_W-1:0]   fl_mem_q [FL_DEPTH];
  logic [FL_PTR_W-1:0] fl_head_q;
  logic [FL_PTR_W-1:0] fl_tail_q;
  logic [FL_CNT_W-1:0] fl_count_q;

  logic fl_empty;
  logic can_alloc;
  logic xfer;
  logic pop;
  logic push;

  // ------------------------------
  // Stall and handshake
  // ------------------------------

  // No bypass of a same-cycle commit push
  assign fl_empty  = (fl_count_q == '0);
  // Only a micro-op with a destination needs a free register
  assign can_alloc = !i_uop.has_dest || !fl_empty;
  assign o_valid   = i_valid && can_alloc;
  assign o_ready   = i_ready && can_alloc;
  assign xfer      = i_valid && o_ready;
  assign pop       = xfer && i_uop.has_dest;
  assign push      = i_commit_valid && i_commit.has_dest;

  // Sources see the RAT before this micro-op's own update
  always_comb begin
    o_uop.pc       = i_uop.pc;
    o_uop.prs1     = rat_q[i_uop.rs1];
    o_uop.prs2     = rat_q[i_uop.rs2];
    o_uop.prd      = i_uop.has_dest ? fl_mem_q[fl_head_q] : '0;
    o_uop.old_prd  = i_uop.has_dest ? rat_q[i_uop.rd] : '0;
    o_uop.has_dest = i_uop.has_dest;
    o_uop.futype   = i_uop.futype;
    o_uop.alu_op   = i_uop.alu_op;
    o_uop.imm      = i_uop.imm;
  end

  // ------------------------------
  // RAT update
  // ------------------------------

  // Identity map out of reset
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < NUM_AREGS; i++) begin
        rat_q[i] <= PREG_W'(i);
      end
    end else if (pop) begin
      rat_q[i_uop.rd] <= fl_mem_q[fl_head_q];
    end
  end

  // ------------------------------
  // Free list
  // ------------------------------

  // Starts full with the registers above the architectural set
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < FL_DEPTH; i++) begin
        fl_mem_q[i] <= PREG_W'(`OOO_NUM_PREGS - FL_DEPTH + i);
      end
      fl_head_q  <= '0;
      fl_tail_q  <= '0;
      fl_count_q <= FL_CNT_W'(FL_DEPTH);
    end else begin
      if (push) begin
        fl_mem_q[fl_tail_q] <= i_commit.old_prd;
        fl_tail_q           <= fl_tail_q + 1'b1;
      end
      if (pop) fl_head_q <= fl_head_q + 1'b1;
      // Push and pop together leave the count alone
      if (push && !pop) begin
        fl_count_q <= fl_count_q + 1'b1;
      end else if (pop && !push) begin
        fl_count_q <= fl_count_q - 1'b1;
      end
    end
  end

endmodule

//--- hdl/ooo_dispatch_rob.sv
`timescale 1ns/1ps
`include "ooo_macros.svh"

module ooo_dispatch_rob (
  input  logic                      clk,
  input  logic                      i_arst_n,
  // From skid 3
  input  ooo_pkg::ren_uop_t         i_uop,
  input  logic                      i_valid,
  output logic                      o_ready,
  // Issue port
  output ooo_pkg::uop_t             o_uop,
  output logic                      o_uop_valid,
  input  logic                      i_uop_ready,
  // Completion
  input  logic                      i_cdb_valid,
  input  logic [`OOO_ROB_TAG_W-1:0] i_cdb_tag,
  // In-order retirement
  output ooo_pkg::commit_t          o_commit,
  output logic                      o_commit_valid
);

  localparam int ROB_DEPTH = `OOO_ROB_DEPTH;
  localparam int TAG_W     = `OOO_ROB_TAG_W;
  localparam int CNT_W     = TAG_W + 1;

  logic [TAG_W-1:0]       head_q;
  logic [TAG_W-1:0]       tail_q;
  logic [CNT_W-1:0]       count_q;
  logic [ROB_DEPTH-1:0]   done_q;
  // Entry payload
  logic [ROB_DEPTH-1:0]   has_dest_q;
  logic [`OOO_PREG_W-1:0] old_prd_q [ROB_DEPTH];

  logic rob_full;
  logic alloc;
  logic retire;

  // ------------------------------
  // Dispatch side
  // ------------------------------

  assign rob_full    = (count_q == CNT_W'(ROB_DEPTH));
  assign o_uop_valid = i_valid && !rob_full;
  assign o_ready     = i_uop_ready && !rob_full;
  assign alloc       = i_valid && o_ready;

  // Tail slot is the tag
  assign o_uop.ren     = i_uop;
  assign o_uop.rob_tag = tail_q;

  // ------------------------------
  // Commit side
  // ------------------------------

  // Done flag is clear on free entries
  assign retire           = done_q[head_q];
  assign o_commit_valid   = retire;
  assign o_commit.rob_tag  = head_q;
  assign o_commit.old_prd  = old_prd_q[head_q];
  assign o_commit.has_dest = has_dest_q[head_q];

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      done_q  <= '0;
    end else begin
      if (alloc) begin
        done_q[tail_q] <= 1'b0;
        tail_q         <= tail_q + 1'b1;
      end
      // Outside completes only tags it already holds
      if (i_cdb_valid) done_q[i_cdb_tag] <= 1'b1;
      if (retire) begin
        done_q[head_q] <= 1'b0;
        head_q         <= head_q + 1'b1;
      end
      if (alloc && !retire) begin
        count_q <= count_q + 1'b1;
      end else if (retire && !alloc) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc) begin
      old_prd_q[tail_q]  <= i_uop.old_prd;
      has_dest_q[tail_q] <= i_uop.has_dest;
    end
  end

endmodule

//--- hdl/ooo_frontend_top.sv
`timescale 1ns/1ps
`include "ooo_macros.svh"

module ooo_frontend_top (
  input  logic                      clk,
  input  logic                      i_arst_n,
  // Wishbone classic to instruction memory
  output logic                      o_wb_cyc,
  output logic                      o_wb_stb,
  output logic [`OOO_PC_W-1:0]      o_wb_adr,
  input  logic [`OOO_XLEN-1:0]      i_wb_dat,
  input  logic                      i_wb_ack,
  // Issue port
  output ooo_pkg::uop_t             o_uop,
  output logic                      o_uop_valid,
  input  logic                      i_uop_ready,
  // Completion
  input  logic                      i_cdb_valid,
  input  logic [`OOO_ROB_TAG_W-1:0] i_cdb_tag,
  // Retirement
  output ooo_pkg::commit_t          o_commit,
  output logic                      o_commit_valid
);
  import ooo_pkg::*;

  // Fetch to decode
  fetch_pkt_t f_pkt;
  fetch_pkt_t s1_pkt;
  logic       f_valid;
  logic       f_ready;
  logic       s1_valid;
  logic       s1_ready;

  // Decode to rename
  dec_uop_t   d_uop;
  dec_uop_t   s2_uop;
  logic       d_valid;
  logic       d_ready;
  logic       s2_valid;
  logic       s2_ready;

  // Rename to dispatch
  ren_uop_t   r_uop;
  ren_uop_t   s3_uop;
  logic       r_valid;
  logic       r_ready;
  logic       s3_valid;
  logic       s3_ready;

  ooo_fetch u_fetch (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .o_wb_cyc (o_wb_cyc),
    .o_wb_stb (o_wb_stb),
    .o_wb_adr (o_wb_adr),
    .i_wb_dat (i_wb_dat),
    .i_wb_ack (i_wb_ack),
    .o_pkt    (f_pkt),
    .o_valid  (f_valid),
    .i_ready  (f_ready)
  );

  ooo_skid_buffer #(.T(fetch_pkt_t)) u_skid_fetch (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_data   (f_pkt),
    .i_valid  (f_valid),
    .o_ready  (f_ready),
    .o_data   (s1_pkt),
    .o_valid  (s1_valid),
    .i_ready  (s1_ready)
  );

  ooo_decode u_decode (
    .i_pkt   (s1_pkt),
    .i_valid (s1_valid),
    .o_ready (s1_ready),
    .o_uop   (d_uop),
    .o_valid (d_valid),
    .i_ready (d_ready)
  );

  ooo_skid_buffer #(.T(dec_uop_t)) u_skid_decode (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_data   (d_uop),
    .i_valid  (d_valid),
    .o_ready  (d_ready),
    .o_data   (s2_uop),
    .o_valid  (s2_valid),
    .i_ready  (s2_ready)
  );

  // Commit feeds the free list and the output together
  ooo_rename u_rename (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_uop          (s2_uop),
    .i_valid        (s2_valid),
    .o_ready        (s2_ready),
    .o_uop          (r_uop),
    .o_valid        (r_valid),
    .i_ready        (r_ready),
    .i_commit       (o_commit),
    .i_commit_valid (o_commit_valid)
  );

  ooo_skid_buffer #(.T(ren_uop_t)) u_skid_rename (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_data   (r_uop),
    .i_valid  (r_valid),
    .o_ready  (r_ready),
    .o_data   (s3_uop),
    .o_valid  (s3_valid),
    .i_ready  (s3_ready)
  );

  ooo_dispatch_rob u_dispatch_rob (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_uop          (s3_uop),
    .i_valid        (s3_valid),
    .o_ready        (s3_ready),
    .o_uop          (o_uop),
    .o_uop_valid    (o_uop_valid),
    .i_uop_ready    (i_uop_ready),
    .i_cdb_valid    (i_cdb_valid),
    .i_cdb_tag      (i_cdb_tag),
    .o_commit       (o_commit),
    .o_commit_valid (o_commit_valid)
  );

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter realtime HALF_PERIOD = 2.0
) (
  output logic o_clk
);

  // 4 ns period, starts low
  initial begin
    o_clk = 1'b0;
  end

  always #(HALF_PERIOD) o_clk = ~o_clk;

endmodule

//--- sim/ooo_frontend_checker.sv
`timescale 1ns/1ps
`include "ooo_macros.svh"

module ooo_frontend_checker (
  input logic                 clk,
  input logic                 i_arst_n,
  input logic                 o_wb_cyc,
  input logic                 o_wb_stb,
  input logic [`OOO_PC_W-1:0] o_wb_adr,
  input logic                 i_wb_ack,
  input ooo_pkg::uop_t        o_uop,
  input logic                 o_uop_valid,
  input logic                 i_uop_ready,
  input logic                 o_commit_valid
);

  // ------------------------------
  // Wishbone master rules
  // ------------------------------

  a_stb_in_cyc: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_wb_stb |-> o_wb_cyc)
    else $error("wishbone stb raised outside a cycle");

  // Request held until the slave acks
  a_req_steady: assert property (@(posedge clk) disable iff (!i_arst_n)
    (o_wb_stb && !i_wb_ack) |=> (o_wb_stb && $stable(o_wb_adr)))
    else $error("wishbone request changed before ack");

  // ------------------------------
  // Issue port and reset
  // ------------------------------

  a_uop_steady: assert property (@(posedge clk) disable iff (!i_arst_n)
    (o_uop_valid && !i_uop_ready) |=> (o_uop_valid && $stable(o_uop)))
    else $error("issue payload changed while stalled");

  a_quiet_in_reset: assert property (@(posedge clk)
    !i_arst_n |-> (!o_uop_valid && !o_commit_valid))
    else $error("valid output during reset");

endmodule

bind ooo_frontend_top ooo_frontend_checker u_checker (
  .clk            (clk),
  .i_arst_n       (i_arst_n),
  .o_wb_cyc       (o_wb_cyc),
  .o_wb_stb       (o_wb_stb),
  .o_wb_adr       (o_wb_adr),
  .i_wb_ack       (i_wb_ack),
  .o_uop          (o_uop),
  .o_uop_valid    (o_uop_valid),
  .i_uop_ready    (i_uop_ready),
  .o_commit_valid (o_commit_valid)
);

//--- sim/ooo_frontend_tb.sv
`timescale 1ns/1ps
`include "ooo_macros.svh"

module ooo_frontend_tb;
  import ooo_pkg::*;

  localparam int MEM_WORDS = 1 << (`OOO_PC_W - 2);
  localparam int TO_CYCLES = 4000;
  localparam int WINDOW    = 200;

  // Expected decode result per program word
  typedef struct packed {
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic        has_dest;
    futype_e     fu;
    alu_op_e     alu;
    logic [31:0] imm;
  } exp_dec_t;

  logic                      clk;
  logic                      arst_n = 1'b0;
  logic                      wb_cyc;
  logic                      wb_stb;
  logic [`OOO_PC_W-1:0]      wb_adr;
  logic [31:0]               wb_dat = '0;
  logic                      wb_ack = 1'b0;
  uop_t                      uop;
  logic                      uop_valid;
  logic                      uop_ready = 1'b0;
  logic                      cdb_valid = 1'b0;
  logic [`OOO_ROB_TAG_W-1:0] cdb_tag = '0;
  commit_t                   commit;
  logic                      commit_valid;

  tb_clock_gen u_clk (.o_clk(clk));

  ooo_frontend_top u_dut (
    .clk            (clk),
    .i_arst_n       (arst_n),
    .o_wb_cyc       (wb_cyc),
    .o_wb_stb       (wb_stb),
    .o_wb_adr       (wb_adr),
    .i_wb_dat       (wb_dat),
    .i_wb_ack       (wb_ack),
    .o_uop          (uop),
    .o_uop_valid    (uop_valid),
    .i_uop_ready    (uop_ready),
    .i_cdb_valid    (cdb_valid),
    .i_cdb_tag      (cdb_tag),
    .o_commit       (commit),
    .o_commit_valid (commit_valid)
  );

  integer   seed = 51953;
  int       errors;
  int       test_errors;
  int       tests_run;
  int       tests_failed;
  bit       timed_out;
  bit       stall_mode;
  bit       cdb_en;
  int       wait_left;

  // Program memory and its decode expectations
  logic [31:0] mem [MEM_WORDS];
  exp_dec_t    exp_dec [MEM_WORDS];

  // Reference model state
  logic [5:0]               m_rat [32];
  logic [5:0]               m_free [$];
  commit_t                  m_rob [$];
  logic [`OOO_ROB_TAG_W-1:0] m_pending [$];
  logic [`OOO_PC_W-1:0]     exp_pc;
  int                       n_uops;
  int                       n_commits;

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic check_eq(input logic [31:0] act, input logic [31:0] exp, input string what);
    if (act !== exp) begin
      $display("FAIL %0t: %s got %0h expected %0h", $time, what, act, exp);
      errors++;
      test_errors++;
    end
  endtask

  // ------------------------------
  // Program generation
  // ------------------------------

  // Modes are mixed (0), stores only (1) and register writers only (2)
  task automatic gen_program(input int mode);
    int          cls;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [11:0] imm12;
    logic [12:0] imm13;
    exp_dec_t    e;
    for (int i = 0; i < MEM_WORDS; i++) begin
      cls   = (mode == 1) ? 3 : (mode == 2) ? rand_below(3) : rand_below(5);
      rs1   = 5'(rand_below(32));
      rs2   = 5'(rand_below(32));
      rd    = (mode == 2) ? 5'(1 + rand_below(31)) : 5'(rand_below(32));
      f3    = 3'(rand_below(8));
      imm12 = 12'(rand_below(4096));
      imm13 = {12'(rand_below(4096)), 1'b0};
      e.rs1 = rs1;
      e.rs2 = '0;
      e.rd  = rd;
      e.has_dest = (rd != 5'd0);
      e.fu  = FU_ALU;
      e.alu = ALU_FUNCT;
      e.imm = {{20{imm12[11]}}, imm12};
      case (cls)
        // R-type, add or sub flavour of funct7
        0: begin
          mem[i] = {(rand_below(2) == 1) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'b0110011};
          e.rs2  = rs2;
          e.imm  = '0;
        end
        1: mem[i] = {imm12, rs1, f3, rd, 7'b0010011};
        2: begin
          mem[i] = {imm12, rs1, f3, rd, 7'b0000011};
          e.fu   = FU_LSU;
          e.alu  = ALU_ADD;
        end
        // S-type splits the immediate around rs2/rs1
        3: begin
          mem[i] = {imm12[11:5], rs2, rs1, f3, imm12[4:0], 7'b0100011};
          e.rs2  = rs2;
          e.fu   = FU_LSU;
          e.alu  = ALU_ADD;
        end
        // B-type scrambled offset
        default: begin
          mem[i] = {imm13[12], imm13[10:5], rs2, rs1, f3, imm13[4:1], imm13[11], 7'b1100011};
          e.rs2  = rs2;
          e.fu   = FU_BRANCH;
          e.alu  = ALU_CMP;
          e.imm  = {{19{imm13[12]}}, imm13};
        end
      endcase
      // Stores and branches write nothing
      if (cls >= 3) begin
        e.has_dest = 1'b0;
      end
      if (!e.has_dest) begin
        e.rd = '0;
      end
      exp_dec[i] = e;
    end
  endtask

  // ------------------------------
  // Memory slave, issue and completion drivers
  // ------------------------------

  // Ack after 0 to 3 wait states
  always @(negedge clk) begin
    if (!arst_n) begin
      wb_ack    = 1'b0;
      wait_left = rand_below(4);
    end else if (wb_ack) begin
      wb_ack    = 1'b0;
      wait_left = rand_below(4);
    end else if (wb_cyc && wb_stb) begin
      if (wait_left == 0) begin
        wb_ack = 1'b1;
        wb_dat = mem[wb_adr[`OOO_PC_W-1:2]];
      end else begin
        wait_left--;
      end
    end
  end

  always @(negedge clk) begin
    int idx;
    uop_ready = arst_n && (!stall_mode || rand_below(3) != 0);
    cdb_valid = 1'b0;
    // Random pick from the outstanding tags
    if (arst_n && cdb_en && m_pending.size() > 0 && rand_below(2) == 1) begin
      idx       = rand_below(m_pending.size());
      cdb_tag   = m_pending[idx];
      cdb_valid = 1'b1;
      m_pending.delete(idx);
    end
  end

  // ------------------------------
  // Reference model
  // ------------------------------

  task automatic check_uop(input uop_t u);
    exp_dec_t                  e;
    logic [5:0]                prd;
    logic [5:0]                old_prd;
    logic [`OOO_ROB_TAG_W-1:0] tag;
    commit_t                   rec;
    e   = exp_dec[exp_pc[`OOO_PC_W-1:2]];
    // ROB tags are handed out in dispatch order
    tag = `OOO_ROB_TAG_W'(n_uops % `OOO_ROB_DEPTH);
    check_eq(32'(u.ren.pc), 32'(exp_pc), "pc");
    check_eq(32'(u.ren.futype), 32'(e.fu), "futype");
    check_eq(32'(u.ren.alu_op), 32'(e.alu), "alu_op");
    check_eq(u.ren.imm, e.imm, "imm");
    check_eq(32'(u.ren.prs1), 32'(m_rat[e.rs1]), "prs1");
    check_eq(32'(u.ren.prs2), 32'(m_rat[e.rs2]), "prs2");
    check_eq(32'(u.ren.has_dest), 32'(e.has_dest), "has_dest");
    check_eq(32'(u.rob_tag), 32'(tag), "rob_tag");
    prd     = '0;
    old_prd = '0;
    if (e.has_dest) begin
      if (m_free.size() == 0) begin
        $display("Model free list empty at %0t while a destination was renamed", $time);
        errors++;
        test_errors++;
      end else begin
        prd = m_free.pop_front();
      end
      old_prd     = m_rat[e.rd];
      m_rat[e.rd] = prd;
    end
    check_eq(32'(u.ren.prd), 32'(prd), "prd");
    check_eq(32'(u.ren.old_prd), 32'(old_prd), "old_prd");
    rec.rob_tag  = tag;
    rec.old_prd  = old_prd;
    rec.has_dest = e.has_dest;
    m_rob.push_back(rec);
    // Completion side returns only tags it was given
    m_pending.push_back(u.rob_tag);
    exp_pc = exp_pc + 12'd4;
    n_uops++;
  endtask

  task automatic check_commit(input commit_t c);
    commit_t rec;
    if (m_rob.size() == 0) begin
      $display("Commit at %0t with no dispatched entry left", $time);
      errors++;
      test_errors++;
    end else begin
      rec = m_rob.pop_front();
      check_eq(32'(c.rob_tag), 32'(rec.rob_tag), "commit tag");
      check_eq(32'(c.old_prd), 32'(rec.old_prd), "commit old_prd");
      check_eq(32'(c.has_dest), 32'(rec.has_dest), "commit has_dest");
      // Freed register goes to the back of the list
      if (rec.has_dest) begin
        m_free.push_back(rec.old_prd);
      end
    end
    n_commits++;
  endtask

  // Commit first so a same-edge free is seen before the next rename
  always @(posedge clk) begin
    if (arst_n) begin
      if (commit_valid) check_commit(commit);
      if (uop_valid && uop_ready) check_uop(uop);
    end
  end

  // ------------------------------
  // Sequencing
  // ------------------------------

  task automatic apply_reset(input int mode);
    @(negedge clk);
    arst_n     = 1'b0;
    stall_mode = 1'b0;
    cdb_en     = 1'b0;
    gen_program(mode);
    for (int i = 0; i < 32; i++) begin
      m_rat[i] = 6'(i);
    end
    m_free.delete();
    for (int i = 32; i < 40; i++) begin
      m_free.push_back(6'(i));
    end
    m_rob.delete();
    m_pending.delete();
    exp_pc      = '0;
    n_uops      = 0;
    n_commits   = 0;
    test_errors = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  endtask

  // Counters settle at the rising edge, read them on the falling one
  task automatic wait_uops(input int n, input string what);
    int cyc;
    cyc = 0;
    while (n_uops < n && !timed_out) begin
      @(negedge clk);
      cyc++;
      if (cyc > TO_CYCLES) begin
        $display("Timeout: only %0d of %0d micro-ops seen (%s)", n_uops, n, what);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic wait_commits(input int n, input string what);
    int cyc;
    cyc = 0;
    while (n_commits < n && !timed_out) begin
      @(negedge clk);
      cyc++;
      if (cyc > TO_CYCLES) begin
        $display("Timeout: only %0d of %0d commits seen (%s)", n_commits, n, what);
        timed_out = 1'b1;
      end
    end
  endtask

  // Stall must hold for the whole window
  task automatic expect_held(input int n, input string what);
    int cyc;
    cyc = 0;
    while (cyc < WINDOW) begin
      @(negedge clk);
      cyc++;
    end
    check_eq(32'(n_uops), 32'(n), what);
  endtask

  task automatic end_test(input int num, input string name);
    tests_run++;
    if (test_errors != 0 || timed_out) tests_failed++;
    $display("test %0d %s: %0d errors, %0d uops, %0d commits",
             num, name, test_errors, n_uops, n_commits);
  endtask

  initial begin
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;

    // Straight flow through fetch, decode and rename
    apply_reset(0);
    cdb_en = 1'b1;
    wait_uops(200, "free flowing issue");
    end_test(1, "mixed program");

    if (!timed_out) begin
      apply_reset(0);
      cdb_en     = 1'b1;
      stall_mode = 1'b1;
      wait_uops(200, "issue with random stalls");
      end_test(2, "issue back-pressure");
    end

    if (!timed_out) begin
      apply_reset(0);
      cdb_en = 1'b1;
      wait_commits(150, "out of order completion");
      end_test(3, "in-order commit");
    end

    // ROB full stall
    if (!timed_out) begin
      apply_reset(1);
      wait_uops(16, "ROB to fill");
      expect_held(16, "uops while ROB full");
      cdb_en = 1'b1;
      wait_uops(40, "flow after ROB drains");
      end_test(4, "ROB full");
    end

    // Free list stall
    if (!timed_out) begin
      apply_reset(2);
      wait_uops(8, "free list to empty");
      expect_held(8, "uops while free list empty");
      cdb_en = 1'b1;
      wait_uops(40, "flow after registers freed");
      end_test(5, "free list empty");
    end

    $display("Summary: %0d tests run, %0d failing, %0d check errors",
             tests_run, tests_failed, errors);
    if (errors == 0 && !timed_out && tests_failed == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+hdl
hdl/ooo_pkg.sv
hdl/ooo_fetch.sv
hdl/ooo_skid_buffer.sv
hdl/ooo_decode.sv
hdl/ooo_rename.sv
hdl/ooo_dispatch_rob.sv
hdl/ooo_frontend_top.sv
sim/tb_clock_gen.sv
sim/ooo_frontend_checker.sv
sim/ooo_frontend_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
  --top-module ooo_frontend_tb -o ooo_sim || { echo "Build failed"; exit 1; }

out=$(./obj_dir/ooo_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Test passed" && exit 0 || exit 1
